/* Bender.yml */
package:
  name: ioddr_tester

sources:
  # packages first, then the design bottom up
  - files:
      - rtl/pattern_pkg.sv
      - rtl/ioddr_cfg_pkg.sv
      - rtl/ddr_pattern_gen.sv
      - rtl/oddr_model.sv
      - rtl/iddr_model.sv
      - rtl/ddr_error_monitor.sv
      - rtl/ioddr_tester.sv

  # testbench and bound assertions
  - target: test
    files:
      - bench/ioddr_tester_props.sv
      - bench/ioddr_tester_tb.sv

/* bench/ioddr_tester_props.sv */
`timescale 1ns/1ps

module ioddr_tester_props
    import ioddr_cfg_pkg::*;
(
    input logic                       CLK,
    input logic                       reset,
    input logic                       mismatch,
    input logic                       err,
    input logic [ERR_COUNT_WIDTH-1:0] err_count
);

    // failed assertions so far
    int fail_count = 0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset and error level
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_reset_clears: assert property (@(posedge CLK)
        reset |=> (!err && (err_count == '0)))
    else begin
        fail_count++;
        $error("err or err_count not cleared by reset");
    end

    a_flag_raises_err: assert property (@(posedge CLK) disable iff (reset)
        mismatch |=> err)
    else begin
        fail_count++;
        $error("err did not rise on the cycle after a flagged mismatch");
    end

    a_err_stretch: assert property (@(posedge CLK) disable iff (reset)
        mismatch |=> err [*STRETCH_CYCLES])
    else begin
        fail_count++;
        $error("err dropped before the stretch time ran out");
    end

    // a full stretch time with no flag ends the level
    a_err_falls: assert property (@(posedge CLK) disable iff (reset)
        !mismatch [*STRETCH_CYCLES] |=> !err)
    else begin
        fail_count++;
        $error("err stayed high after the stretch time ran out");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mismatch counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_count_step: assert property (@(posedge CLK) disable iff (reset)
        mismatch && (err_count != '1) |=> (err_count == $past(err_count) + 1'b1))
    else begin
        fail_count++;
        $error("err_count did not step by one on a flagged mismatch");
    end

    a_count_hold: assert property (@(posedge CLK) disable iff (reset)
        !mismatch |=> $stable(err_count))
    else begin
        fail_count++;
        $error("err_count changed without a flagged mismatch");
    end

endmodule

bind ddr_error_monitor ioddr_tester_props props_i (
    .CLK       (CLK),
    .reset     (reset),
    .mismatch  (mismatch),
    .err       (err),
    .err_count (err_count)
);

/* bench/ioddr_tester_tb.sv */
`timescale 1ns/1ps

module ioddr_tester_tb
    import pattern_pkg::*;
    import ioddr_cfg_pkg::*;
();

    logic                       CLK = 1'b0;
    logic                       reset;
    logic                       fault;
    logic                       d;
    logic                       q;
    logic                       err;
    logic [ERR_COUNT_WIDTH-1:0] err_count;

    int errors        = 0;
    int tests_run     = 0;
    int tests_failed  = 0;
    int exp_faults    = 0;
    int errors_before = 0;
    int props_before  = 0;

    always #2 CLK = ~CLK;

    // pin loopback, fault flips whatever is on the wire
    assign d = q ^ fault;

    ioddr_tester #(
        .EDGE_MODE (SAME_EDGE)
    ) ioddr_tester_i (
        .CLK       (CLK),
        .reset     (reset),
        .d         (d),
        .q         (q),
        .err       (err),
        .err_count (err_count)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int assertion_failures();
        return ioddr_tester_i.error_monitor_i.props_i.fail_count;
    endfunction

    task automatic expect_value(input string what, input int got, input int want);
        assert (got == want) else begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic expect_at_least(input string what, input int got, input int low);
        assert (got >= low) else begin
            errors++;
            $display("** Error at %0t ns: %s is %0d, expected at least %0d",
                     $time, what, got, low);
        end
    endtask

    // one full clock of corruption, hits both bits of one pair
    task automatic pulse_fault();
        @(posedge CLK);
        fault <= 1'b1;
        @(posedge CLK);
        fault <= 1'b0;
        exp_faults++;
    endtask

    // cycles counts falling edges up to and including the one that saw the level
    task automatic wait_err(input logic level, input int limit, input string what,
                            output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < limit) begin
            @(negedge CLK);
            cycles++;
            seen = (err == level);
        end
        if (!seen) begin
            errors++;
            $display("timeout: %s within %0d cycles", what, limit);
        end
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge CLK);
            expect_value("err", err, 0);
            expect_value("err_count", err_count, exp_faults);
        end
    endtask

    task automatic start_test();
        errors_before = errors;
        props_before  = assertion_failures();
    endtask

    task automatic end_test(input string name);
        bit ok;
        ok = (errors == errors_before) && (assertion_failures() == props_before);
        tests_run++;
        if (!ok) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", tests_run, name, ok ? "ok" : "FAILED");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int cycles;
        int hold;
        int gap;
        int high_total;

        void'($urandom(32'h51));
        reset = 1'b1;
        fault = 1'b0;
        $display("loopback run, pattern seed %h", PATTERN_SEED);
        repeat (16) @(posedge CLK);
        reset <= 1'b0;

        start_test();
        check_quiet(200);
        end_test("clean loopback");

        start_test();
        pulse_fault();
        wait_err(1'b1, LATENCY_SAME + 3, "err did not rise after a fault", cycles);
        expect_value("err_count", err_count, exp_faults);
        end_test("single fault");

        start_test();
        wait_err(1'b0, STRETCH_CYCLES * 2, "err did not fall after the stretch", cycles);
        expect_at_least("err high cycles", cycles, STRETCH_CYCLES);
        check_quiet(50);
        end_test("error stretch");

        start_test();
        for (int i = 0; i < 20; i++) begin
            gap = LATENCY_SAME + 2 + $urandom_range(0, 30);
            repeat (gap) @(posedge CLK);
            pulse_fault();
        end
        // let the last flag reach the counter
        repeat (LATENCY_SAME + 3) @(posedge CLK);
        wait_err(1'b0, STRETCH_CYCLES * 2, "err did not fall after the fault burst", cycles);
        expect_value("err_count", err_count, exp_faults);
        end_test("random faults");

        start_test();
        pulse_fault();
        wait_err(1'b1, LATENCY_SAME + 3, "err did not rise after the first fault", cycles);
        hold = $urandom_range(10, 40);
        repeat (hold) begin
            @(negedge CLK);
            expect_value("err", err, 1);
        end
        pulse_fault();
        wait_err(1'b0, STRETCH_CYCLES * 3, "err did not fall after the second fault", cycles);
        high_total = hold + 1 + cycles;
        expect_at_least("err high after second fault", cycles - 1, STRETCH_CYCLES);
        expect_at_least("err high overall", high_total, STRETCH_CYCLES + hold + 2);
        expect_value("err_count", err_count, exp_faults);
        end_test("fault during error");

        start_test();
        pulse_fault();
        wait_err(1'b1, LATENCY_SAME + 3, "err did not rise before reset", cycles);
        @(posedge CLK);
        reset <= 1'b1;
        repeat (16) @(posedge CLK);
        @(negedge CLK);
        expect_value("err in reset", err, 0);
        expect_value("err_count in reset", err_count, 0);
        expect_value("q in reset", q, 0);
        @(posedge CLK);
        reset <= 1'b0;
        exp_faults = 0;
        check_quiet(200);
        end_test("reset mid-run");

        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, assertion_failures());
        if (tests_failed == 0 && errors == 0 && assertion_failures() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* ioddr_tester.f */
rtl/pattern_pkg.sv
rtl/ioddr_cfg_pkg.sv
rtl/ddr_pattern_gen.sv
rtl/oddr_model.sv
rtl/iddr_model.sv
rtl/ddr_error_monitor.sv
rtl/ioddr_tester.sv
bench/ioddr_tester_props.sv
bench/ioddr_tester_tb.sv

/* rtl/ddr_error_monitor.sv */
`timescale 1ns/1ps

module ddr_error_monitor
    import ioddr_cfg_pkg::*;
#(
    parameter ddr_edge_e EDGE_MODE = SAME_EDGE
) (
    input  logic                       CLK,
    input  logic                       reset,
    input  ddr_pair_t                  tx_pair,
    input  ddr_pair_t                  rx_pair,
    output logic                       err,
    output logic [ERR_COUNT_WIDTH-1:0] err_count
);

    localparam int LATENCY = loop_latency(EDGE_MODE);

    ddr_pair_t                expect_line [LATENCY];
    ddr_pair_t                expected;
    logic                     mismatch;
    logic [STRETCH_WIDTH-1:0] stretch_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference delay line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // matches the loop latency so the last stage lines up with rx_pair
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < LATENCY; i++) begin
                expect_line[i] <= '0;
            end
        end else begin
            expect_line[0] <= tx_pair;
            for (int i = 1; i < LATENCY; i++) begin
                expect_line[i] <= expect_line[i-1];
            end
        end
    end

    assign expected = expect_line[LATENCY-1];

    // registered compare
    always_ff @(posedge CLK) begin
        if (reset) begin
            mismatch <= 1'b0;
        end else begin
            mismatch <= (rx_pair != expected);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error stretch and count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // every flag restarts the full hold time
    always_ff @(posedge CLK) begin
        if (reset) begin
            stretch_cnt <= '0;
        end else if (mismatch) begin
            stretch_cnt <= STRETCH_WIDTH'(STRETCH_CYCLES);
        end else if (stretch_cnt != '0) begin
            stretch_cnt <= stretch_cnt - 1'b1;
        end
    end

    assign err = (stretch_cnt != '0);

    // sticks at all ones
    always_ff @(posedge CLK) begin
        if (reset) begin
            err_count <= '0;
        end else if (mismatch && (err_count != '1)) begin
            err_count <= err_count + 1'b1;
        end
    end

endmodule

/* rtl/ddr_pattern_gen.sv */
`timescale 1ns/1ps

module ddr_pattern_gen
    import pattern_pkg::*;
    import ioddr_cfg_pkg::*;
(
    input  logic      CLK,
    input  logic      reset,
    output ddr_pair_t tx_pair
);

    logic [PATTERN_WIDTH-1:0] lfsr;
    logic [PATTERN_WIDTH-1:0] lfsr_next;

    // one Fibonacci shift, new bit enters at the bottom
    function automatic logic [PATTERN_WIDTH-1:0] lfsr_step(
        input logic [PATTERN_WIDTH-1:0] s
    );
        logic fb;
        fb = ^(s & PATTERN_TAPS);
        return {s[PATTERN_WIDTH-2:0], fb};
    endfunction

    // advance once per DDR phase so both bits are fresh
    always_comb begin
        lfsr_next = lfsr;
        for (int i = 0; i < PATTERN_STEPS; i++) begin
            lfsr_next = lfsr_step(lfsr_next);
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            lfsr <= PATTERN_SEED;
        end else begin
            lfsr <= lfsr_next;
        end
    end

    // bit 1 was shifted in first, so it leads on the pin
    assign tx_pair.d1 = lfsr[1];
    assign tx_pair.d2 = lfsr[0];

endmodule

/* rtl/iddr_model.sv */
`timescale 1ns/1ps

module iddr_model
    import ioddr_cfg_pkg::*;
#(
    parameter ddr_edge_e EDGE_MODE = SAME_EDGE
) (
    input  logic      CLK,
    input  logic      reset,
    input  logic      d,
    output ddr_pair_t rx_pair
);

    logic      cap_fall;
    logic      cap_fall_q;
    logic      cap_rise;
    ddr_pair_t align;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pin capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // falling edge sees the bit held through the high phase
    always_ff @(negedge CLK) begin
        if (reset) begin
            cap_fall <= 1'b0;
        end else begin
            cap_fall <= d;
        end
    end

    // rising edge sees the low phase bit of the same period
    always_ff @(posedge CLK) begin
        if (reset) begin
            cap_rise <= 1'b0;
        end else begin
            cap_rise <= d;
        end
    end

    // pair both halves up on the rising edge
    always_comb begin
        align.d1 = cap_fall_q;
        align.d2 = cap_rise;
    end

    // falling capture must be held until the rising one lands
    always_ff @(posedge CLK) begin
        if (reset) begin
            cap_fall_q <= 1'b0;
        end else begin
            cap_fall_q <= cap_fall;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    generate
        if (EDGE_MODE == OPPOSITE_EDGE) begin : g_reclock
            ddr_pair_t align_q;

            always_ff @(posedge CLK) begin
                if (reset) begin
                    align_q <= '0;
                end else begin
                    align_q <= align;
                end
            end

            assign rx_pair = align_q;
        end else begin : g_direct
            assign rx_pair = align;
        end
    endgenerate

endmodule

/* rtl/ioddr_cfg_pkg.sv */
package ioddr_cfg_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DDR edge mode and data pair
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        SAME_EDGE     = 1'b0,
        OPPOSITE_EDGE = 1'b1
    } ddr_edge_e;

    // d1 goes out in the high phase, d2 in the low phase
    typedef struct packed {
        logic d1;
        logic d2;
    } ddr_pair_t;

    // cycles from generator pair to aligned received pair
    localparam int LATENCY_SAME     = 2;
    localparam int LATENCY_OPPOSITE = 3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // error reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // short stretch so that simulation stays quick
    localparam int STRETCH_CYCLES  = 64;
    localparam int STRETCH_WIDTH   = 7;
    localparam int ERR_COUNT_WIDTH = 16;

    function automatic int loop_latency(input ddr_edge_e mode);
        return (mode == OPPOSITE_EDGE) ? LATENCY_OPPOSITE : LATENCY_SAME;
    endfunction

endpackage

/* rtl/ioddr_tester.sv */
`timescale 1ns/1ps

module ioddr_tester
    import ioddr_cfg_pkg::*;
#(
    parameter ddr_edge_e EDGE_MODE = SAME_EDGE
) (
    input  logic                       CLK,
    input  logic                       reset,
    input  logic                       d,
    output logic                       q,
    output logic                       err,
    output logic [ERR_COUNT_WIDTH-1:0] err_count
);

    ddr_pair_t tx_pair;
    ddr_pair_t rx_pair;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // transmit side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ddr_pattern_gen pattern_gen_i (
        .CLK     (CLK),
        .reset   (reset),
        .tx_pair (tx_pair)
    );

    oddr_model #(
        .EDGE_MODE (EDGE_MODE)
    ) oddr_i (
        .CLK     (CLK),
        .reset   (reset),
        .tx_pair (tx_pair),
        .q       (q)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // receive side and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    iddr_model #(
        .EDGE_MODE (EDGE_MODE)
    ) iddr_i (
        .CLK     (CLK),
        .reset   (reset),
        .d       (d),
        .rx_pair (rx_pair)
    );

    // expected pair is tx_pair delayed inside the monitor
    ddr_error_monitor #(
        .EDGE_MODE (EDGE_MODE)
    ) error_monitor_i (
        .CLK       (CLK),
        .reset     (reset),
        .tx_pair   (tx_pair),
        .rx_pair   (rx_pair),
        .err       (err),
        .err_count (err_count)
    );

endmodule

/* rtl/oddr_model.sv */
`timescale 1ns/1ps

module oddr_model
    import ioddr_cfg_pkg::*;
#(
    parameter ddr_edge_e EDGE_MODE = SAME_EDGE
) (
    input  logic      CLK,
    input  logic      reset,
    input  ddr_pair_t tx_pair,
    output logic      q
);

    logic d1_r;
    logic d2_r;
    logic d2_low;
    logic phase_rise;
    logic phase_fall;
    logic phase_high;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rising edge capture of both bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge CLK) begin
        if (reset) begin
            d1_r       <= 1'b0;
            d2_r       <= 1'b0;
            phase_rise <= 1'b0;
        end else begin
            d1_r       <= tx_pair.d1;
            d2_r       <= tx_pair.d2;
            phase_rise <= ~phase_fall;
        end
    end

    // phase flag from registers, the pin never moves before a sampling edge
    always_ff @(negedge CLK) begin
        if (reset) begin
            phase_fall <= 1'b0;
        end else begin
            phase_fall <= phase_rise;
        end
    end

    assign phase_high = phase_rise ^ phase_fall;

    // second bit source for the low phase
    generate
        if (EDGE_MODE == OPPOSITE_EDGE) begin : g_fall_stage
            logic d2_f;

            always_ff @(negedge CLK) begin
                if (reset) begin
                    d2_f <= 1'b0;
                end else begin
                    d2_f <= d2_r;
                end
            end

            assign d2_low = d2_f;
        end else begin : g_rise_only
            assign d2_low = d2_r;
        end
    endgenerate

    assign q = phase_high ? d1_r : d2_low;

endmodule

/* rtl/pattern_pkg.sv */
package pattern_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // LFSR test pattern
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // register length
    localparam int PATTERN_WIDTH = 16;

    // x^16 + x^14 + x^13 + x^11 + 1, maximal length
    // feedback from bits 15, 13, 12 and 10
    localparam logic [PATTERN_WIDTH-1:0] PATTERN_TAPS = 16'hB400;

    // any nonzero value works, all-zero would lock up
    localparam logic [PATTERN_WIDTH-1:0] PATTERN_SEED = 16'hACE1;

    // shift steps per clock, one per DDR phase
    localparam int PATTERN_STEPS = 2;

endpackage
